/* filelist.f */
+incdir+testbench
logic/isa_pkg.sv
logic/datapath_pkg.sv
logic/unified_ram.sv
logic/program_counter.sv
logic/control_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/cpu_top.sv
testbench/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f filelist.f --Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation run returned an error"
	cat sim.log
	exit 1
fi

cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1

/* testbench/cpu_tests.svh */
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// encoders straight from the instruction formats
function automatic logic [15:0] reg_instr(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] ext, input logic [3:0] rs);
	return {op, rd, ext, rs};
endfunction

function automatic logic [15:0] imm_instr(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [7:0] imm8);
	return {op, rd, imm8};
endfunction

// expected result of a register alu op
function automatic logic [15:0] ref_op(input logic [3:0] ext, input logic [15:0] a,
                                       input logic [15:0] b);
	case (ext)
		ext_add: return a + b;
		ext_sub: return a - b;
		ext_and: return a & b;
		ext_or:  return a | b;
		ext_xor: return a ^ b;
		default: return b; // mov
	endcase
endfunction

function automatic logic [3:0] pick_ext(input int i);
	case (i)
		0: return ext_add;
		1: return ext_sub;
		2: return ext_and;
		3: return ext_or;
		4: return ext_xor;
		default: return ext_mov;
	endcase
endfunction

task automatic start_test();
	for (int i = 0; i < 256; i++)
		image[i] = '0;
	load_ptr = 0;
endtask

task automatic put(input logic [15:0] w);
	image[load_ptr] = w;
	load_ptr++;
endtask

task automatic end_test(input string name, input int err_before);
	tests++;
	$display("test %s done, %0d errors", name, errors - err_before);
endtask

// r3 = r1 op r2 stored at r15 which then advances
task automatic alu_case(input logic [3:0] ext);
	put(reg_instr(op_reg, 4'd3, ext_mov, 4'd1));
	put(reg_instr(op_reg, 4'd3, ext, 4'd2));
	put(reg_instr(op_mem, 4'd3, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
endtask

// cmpi then a branch over a marker store
task automatic branch_case(input logic [7:0] cmp_imm, input logic [3:0] cond);
	put(imm_instr(op_cmpi, 4'd3, cmp_imm));
	put(imm_instr(op_bcond, cond, 8'h02)); // skip one word
	put(reg_instr(op_mem, 4'd4, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
endtask

task automatic alu_program(input int dst);
	put(imm_instr(op_movi, 4'd15, 8'(dst)));
	for (int i = 0; i < 6; i++)
		alu_case(pick_ext(i));
	put(16'hF000); // halt
endtask

task automatic test_reg_alu();
	int e;
	e = errors;
	start_test();
	put(imm_instr(op_movi, 4'd1, 8'hC3));
	put(imm_instr(op_movi, 4'd2, 8'h35));
	alu_program(8'h80);
	load_program();
	run_to_halt();
	check_word("alu_out", 16'h00C3, first_alu); // movi zero-extends
	for (int i = 0; i < 6; i++)
		expect_mem(8'h80 + i, ref_op(pick_ext(i), 16'h00C3, 16'h0035));
	check_bit("halted", 1'b1, halted);
	end_test("reg_alu", e);
endtask

task automatic test_immediates();
	int e;
	e = errors;
	start_test();
	put(imm_instr(op_movi, 4'd15, 8'hB0));
	put(imm_instr(op_movi, 4'd1, 8'h10));
	put(imm_instr(op_addi, 4'd1, 8'hFE)); // minus two
	put(reg_instr(op_mem, 4'd1, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
	put(imm_instr(op_movi, 4'd2, 8'hF0)); // no sign extension
	put(reg_instr(op_mem, 4'd2, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
	put(imm_instr(op_movi, 4'd3, 8'h05));
	put(imm_instr(op_movi, 4'd4, 8'h11)); // marker
	branch_case(8'h05, cond_eq); // z set so taken
	branch_case(8'h05, cond_ne);
	branch_case(8'h07, cond_lt); // n set so taken
	branch_case(8'h07, cond_ge);
	put(16'hF000);
	load_program();
	run_to_halt();
	expect_mem(8'hB0, 16'h000E);
	expect_mem(8'hB1, 16'h00F0);
	expect_mem(8'hB2, 16'h0000);
	expect_mem(8'hB3, 16'h0011);
	expect_mem(8'hB4, 16'h0000);
	expect_mem(8'hB5, 16'h0011);
	end_test("immediates", e);
endtask

task automatic test_load_store();
	int e;
	e = errors;
	start_test();
	image[8'hC0] = 16'h1234;
	image[8'hC1] = 16'hFFFF;
	image[8'hC2] = 16'hABCD;
	image[8'hC3] = 16'h0F0F;
	image[8'hD1] = 16'h5A5A; // overwritten with zero
	put(imm_instr(op_movi, 4'd14, 8'hC0));
	put(reg_instr(op_mem, 4'd1, ext_load, 4'd14));
	put(imm_instr(op_addi, 4'd1, 8'h10));
	put(imm_instr(op_movi, 4'd14, 8'hC1));
	put(reg_instr(op_mem, 4'd2, ext_load, 4'd14));
	put(imm_instr(op_addi, 4'd2, 8'h01)); // wraps to zero
	put(imm_instr(op_movi, 4'd15, 8'hD0));
	put(reg_instr(op_mem, 4'd1, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
	put(reg_instr(op_mem, 4'd2, ext_stor, 4'd15));
	put(16'hF000);
	load_program();
	run_to_halt();
	expect_mem(8'hD0, 16'h1244);
	expect_mem(8'hD1, 16'h0000);
	expect_mem(8'hC0, 16'h1234);
	expect_mem(8'hC1, 16'hFFFF);
	expect_mem(8'hC2, 16'hABCD);
	expect_mem(8'hC3, 16'h0F0F);
	end_test("load_store", e);
endtask

task automatic test_branches();
	int e;
	e = errors;
	start_test();
	put(imm_instr(op_movi, 4'd1, 8'h05)); // counter
	put(imm_instr(op_movi, 4'd2, 8'h00)); // iterations
	put(imm_instr(op_movi, 4'd6, 8'h00));
	put(imm_instr(op_addi, 4'd2, 8'h01)); // loop top
	put(imm_instr(op_addi, 4'd1, 8'hFF));
	put(reg_instr(op_reg, 4'd1, ext_cmp, 4'd6));
	put(imm_instr(op_bcond, cond_ne, 8'hFD)); // back three
	put(imm_instr(op_movi, 4'd15, 8'h60));
	put(reg_instr(op_mem, 4'd2, ext_stor, 4'd15));
	put(imm_instr(op_addi, 4'd15, 8'h01));
	put(imm_instr(op_movi, 4'd3, 8'h05));
	put(imm_instr(op_movi, 4'd4, 8'h11));
	branch_case(8'h07, cond_lo); // l set so taken
	branch_case(8'h07, cond_hs);
	branch_case(8'h03, cond_lo);
	branch_case(8'h03, cond_hs); // l clear so taken
	branch_case(8'hFE, cond_lt); // 5 vs -2 leaves n clear
	branch_case(8'hFE, cond_ge); // taken
	put(16'hF000);
	load_program();
	run_to_halt();
	expect_mem(8'h60, 16'h0005);
	expect_mem(8'h61, 16'h0000);
	expect_mem(8'h62, 16'h0011);
	expect_mem(8'h63, 16'h0011);
	expect_mem(8'h64, 16'h0000);
	expect_mem(8'h65, 16'h0011);
	expect_mem(8'h66, 16'h0000);
	end_test("branches", e);
endtask

task automatic test_jumps_carry();
	int e;
	int p;
	e = errors;
	start_test();
	put(imm_instr(op_movi, 4'd15, 8'hE0));
	put(imm_instr(op_movi, 4'd13, 8'hE1)); // poison target
	put(imm_instr(op_movi, 4'd4, 8'h11));
	put(imm_instr(op_movi, 4'd9, 8'hEE));
	p = load_ptr;
	put(imm_instr(op_movi, 4'd7, 8'(p + 3)));
	put(reg_instr(op_mem, cond_uc, ext_jcond, 4'd7));
	put(reg_instr(op_mem, 4'd9, ext_stor, 4'd13)); // poison
	put(imm_instr(op_movi, 4'd3, 8'h05));
	put(imm_instr(op_cmpi, 4'd3, 8'h05)); // z set
	p = load_ptr;
	put(imm_instr(op_movi, 4'd7, 8'(p + 3))); // movi keeps flags
	put(reg_instr(op_mem, cond_eq, ext_jcond, 4'd7));
	put(reg_instr(op_mem, 4'd9, ext_stor, 4'd13));
	put(reg_instr(op_mem, cond_ne, ext_jcond, 4'd7)); // not taken
	put(reg_instr(op_mem, 4'd4, ext_stor, 4'd15));
	put(imm_instr(op_movi, 4'd1, 8'h00)); // 0001_fff0 + 0002_0020
	put(imm_instr(op_addi, 4'd1, 8'hF0));
	put(imm_instr(op_movi, 4'd2, 8'h01));
	put(imm_instr(op_movi, 4'd10, 8'h02));
	put(imm_instr(op_movi, 4'd11, 8'h20));
	put(imm_instr(op_movi, 4'd13, 8'hE2));
	put(reg_instr(op_reg, 4'd1, ext_add, 4'd11));
	put(reg_instr(op_reg, 4'd2, ext_addc, 4'd10));
	put(reg_instr(op_mem, 4'd1, ext_stor, 4'd13));
	put(imm_instr(op_addi, 4'd13, 8'h01));
	put(reg_instr(op_mem, 4'd2, ext_stor, 4'd13));
	put(16'hF000);
	load_program();
	run_to_halt();
	expect_mem(8'hE0, 16'h0011);
	expect_mem(8'hE1, 16'h0000);
	expect_mem(8'hE2, 16'h0010);
	expect_mem(8'hE3, 16'h0004);
	end_test("jumps_carry", e);
endtask

task automatic test_random_ops();
	int e;
	logic [15:0] a;
	logic [15:0] b;
	e = errors;
	for (int r = 0; r < 4; r++) begin
		start_test();
		a = lcg_next();
		b = lcg_next();
		image[8'h90] = a;
		image[8'h91] = b;
		put(imm_instr(op_movi, 4'd14, 8'h90));
		put(reg_instr(op_mem, 4'd1, ext_load, 4'd14));
		put(imm_instr(op_addi, 4'd14, 8'h01));
		put(reg_instr(op_mem, 4'd2, ext_load, 4'd14));
		alu_program(8'hA0);
		load_program();
		run_to_halt();
		for (int i = 0; i < 6; i++)
			expect_mem(8'hA0 + i, ref_op(pick_ext(i), a, b));
	end
	end_test("random_ops", e);
endtask

`endif

/* testbench/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb import isa_pkg::*, datapath_pkg::*; ();

	logic                 clk;
	logic                 reset;
	logic [9:0]           dbg_addr;
	logic [data_bits-1:0] dbg_wdata;
	logic                 dbg_we;
	logic [data_bits-1:0] dbg_rdata;
	logic [data_bits-1:0] alu_out;
	logic                 halted;

	int checks;
	int errors;
	int tests;

	// memory image written through port b before each run
	logic [data_bits-1:0] image [256];
	int                   load_ptr; // next program address

	logic [data_bits-1:0] first_alu; // alu_out while the word at address 0 executes

	logic [31:0] lcg_state = 32'd25535;

	cpu_top #(.addr_bits(10)) cpu_top_i (
		.clk       (clk),
		.reset     (reset),
		.dbg_addr  (dbg_addr),
		.dbg_wdata (dbg_wdata),
		.dbg_we    (dbg_we),
		.dbg_rdata (dbg_rdata),
		.alu_out   (alu_out),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	function automatic logic [data_bits-1:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16]; // upper half spreads better
	endfunction

	task automatic check_word(input string name, input logic [data_bits-1:0] expected,
	                          input logic [data_bits-1:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	// holds reset low while the whole image goes in
	task automatic load_program();
		@(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			dbg_addr  <= 10'(i);
			dbg_wdata <= image[i];
			dbg_we    <= 1'b1;
		end
		@(posedge clk);
		dbg_we <= 1'b0;
	endtask

	task automatic run_to_halt();
		int n;
		n = 0;
		first_alu = 'x;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk); // first fetch
		while (!halted && n < 2000) begin
			@(negedge clk); // halted settled mid-cycle
			n++;
			if (n == 2)
				first_alu = alu_out; // execute cycle of the first word
		end
		if (!halted) begin
			$display("timeout: the processor did not halt within 2000 cycles");
			$display("Simulation failed");
			$finish;
		end
	endtask

	// port b read with data one edge after the address
	task automatic read_word(input int addr, output logic [data_bits-1:0] data);
		@(posedge clk);
		dbg_addr <= 10'(addr);
		@(posedge clk);
		@(negedge clk);
		data = dbg_rdata;
	endtask

	task automatic expect_mem(input int addr, input logic [data_bits-1:0] expected);
		logic [data_bits-1:0] data;
		read_word(addr, data);
		check_word($sformatf("mem[%h]", addr[9:0]), expected, data);
	endtask

	`include "cpu_tests.svh"

	initial begin
		reset     = 1'b0;
		dbg_addr  = '0;
		dbg_wdata = '0;
		dbg_we    = 1'b0;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		load_ptr  = 0;
		repeat (3) @(posedge clk); // reset for 3 cycles
		test_reg_alu();
		test_immediates();
		test_load_store();
		test_branches();
		test_jumps_carry();
		test_random_ops();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top import datapath_pkg::*; #(
	parameter int addr_bits = 10
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire [addr_bits-1:0]  dbg_addr,  // ram port b
	input  wire [data_bits-1:0]  dbg_wdata,
	input  wire                  dbg_we,
	output logic [data_bits-1:0] dbg_rdata,
	output logic [data_bits-1:0] alu_out, // live alu result
	output logic                 halted
);

	// decoder strobes
	logic                     pc_en, branch, jump, reg_we;
	logic                     imm_sel, wb_sel, ls_sel, mem_we;
	logic [7:0]               disp;
	logic [reg_addr_bits-1:0] waddr, raddr_a, raddr_b;
	logic [alu_op_bits-1:0]   alu_op;
	logic [data_bits-1:0]     imm;
	logic [flag_bits-1:0]     flags_q, flags_next;

	// datapath
	logic [data_bits-1:0] pc, q_a, rdata_a, rdata_b;
	logic [data_bits-1:0] alu_b, alu_result, wdata;
	logic [addr_bits-1:0] mem_addr_a;

	assign mem_addr_a = ls_sel ? rdata_b[addr_bits-1:0] : pc[addr_bits-1:0]; // load/store vs fetch
	assign alu_b      = imm_sel ? imm : rdata_b; // immediate operand
	assign wdata      = wb_sel ? q_a : alu_result; // write-back source
	assign alu_out    = alu_result;

	unified_ram #(.addr_bits(addr_bits)) ram_i (
		.clk    (clk),
		.data_a (rdata_a), // store data from rdest
		.data_b (dbg_wdata),
		.addr_a (mem_addr_a),
		.addr_b (dbg_addr),
		.we_a   (mem_we),
		.we_b   (dbg_we),
		.q_a    (q_a),
		.q_b    (dbg_rdata)
	);

	program_counter pc_i (
		.clk    (clk),
		.reset  (reset),
		.en     (pc_en),
		.branch (branch),
		.jump   (jump),
		.disp   (disp),
		.target (rdata_b), // jcond target in rsrc
		.pc     (pc)
	);

	control_decoder ctrl_i (
		.clk        (clk),
		.reset      (reset),
		.instr      (q_a),
		.flags_next (flags_next),
		.flags_q    (flags_q),
		.pc_en      (pc_en),
		.branch     (branch),
		.jump       (jump),
		.disp       (disp),
		.reg_we     (reg_we),
		.waddr      (waddr),
		.raddr_a    (raddr_a),
		.raddr_b    (raddr_b),
		.imm_sel    (imm_sel),
		.wb_sel     (wb_sel),
		.ls_sel     (ls_sel),
		.mem_we     (mem_we),
		.alu_op     (alu_op),
		.imm        (imm),
		.halted     (halted)
	);

	register_file regs_i (
		.clk     (clk),
		.reset   (reset),
		.we      (reg_we),
		.waddr   (waddr),
		.wdata   (wdata),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	alu alu_i (
		.a      (rdata_a),
		.b      (alu_b),
		.alu_op (alu_op),
		.cin    (flags_q[flag_c]), // addc carry in
		.result (alu_result),
		.flags  (flags_next)
	);

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import datapath_pkg::*; (
	input  wire  [data_bits-1:0]   a, // rdest
	input  wire  [data_bits-1:0]   b, // rsrc or immediate
	input  wire  [alu_op_bits-1:0] alu_op,
	input  wire                    cin, // stored carry
	output logic [data_bits-1:0]   result,
	output logic [flag_bits-1:0]   flags
);

	logic [data_bits:0] sum; // extra bit is the carry
	logic               ovf;

	always_comb begin
		sum    = '0;
		ovf    = 1'b0;
		result = '0;
		case (alu_op)
			alu_add: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[data_bits-1:0];
				ovf    = (a[data_bits-1] == b[data_bits-1]) &&
				         (result[data_bits-1] != a[data_bits-1]);
			end
			alu_addc: begin
				sum    = {1'b0, a} + {1'b0, b} + {{data_bits{1'b0}}, cin};
				result = sum[data_bits-1:0];
				ovf    = (a[data_bits-1] == b[data_bits-1]) &&
				         (result[data_bits-1] != a[data_bits-1]);
			end
			alu_sub: begin
				sum    = {1'b0, a} - {1'b0, b}; // top bit is the borrow
				result = sum[data_bits-1:0];
				ovf    = (a[data_bits-1] != b[data_bits-1]) &&
				         (result[data_bits-1] != a[data_bits-1]);
			end
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

	// compare flags come from the operands, not the result
	always_comb begin
		flags         = '0;
		flags[flag_c] = sum[data_bits];
		flags[flag_l] = a < b;
		flags[flag_f] = ovf;
		flags[flag_z] = result == '0;
		flags[flag_n] = $signed(a) < $signed(b);
	end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file import datapath_pkg::*; (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      we,
	input  wire  [reg_addr_bits-1:0] waddr,
	input  wire  [data_bits-1:0]     wdata,
	input  wire  [reg_addr_bits-1:0] raddr_a, // rdest
	input  wire  [reg_addr_bits-1:0] raddr_b, // rsrc
	output logic [data_bits-1:0]     rdata_a,
	output logic [data_bits-1:0]     rdata_b
);

	logic [data_bits-1:0] regs [reg_count];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0; // all clear, r0 is an ordinary register
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// async reads
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

/* logic/control_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module control_decoder import isa_pkg::*, datapath_pkg::*; (
	input  wire                      clk,
	input  wire                      reset,
	input  wire  [data_bits-1:0]     instr,      // q_a of the ram
	input  wire  [flag_bits-1:0]     flags_next, // from alu
	output logic [flag_bits-1:0]     flags_q,    // stored flags, carry feeds alu
	output logic                     pc_en,
	output logic                     branch,
	output logic                     jump,
	output logic [7:0]               disp,
	output logic                     reg_we,
	output logic [reg_addr_bits-1:0] waddr,
	output logic [reg_addr_bits-1:0] raddr_a,
	output logic [reg_addr_bits-1:0] raddr_b,
	output logic                     imm_sel,
	output logic                     wb_sel,
	output logic                     ls_sel,
	output logic                     mem_we,
	output logic [alu_op_bits-1:0]   alu_op,
	output logic [data_bits-1:0]     imm,
	output logic                     halted
);

	// fsm states
	localparam logic [2:0] s_fetch    = 3'd0;
	localparam logic [2:0] s_decode   = 3'd1;
	localparam logic [2:0] s_execute  = 3'd2;
	localparam logic [2:0] s_mem_wait = 3'd3;
	localparam logic [2:0] s_mem_wb   = 3'd4;
	localparam logic [2:0] s_halted   = 3'd5;

	logic [2:0] state, state_next;
	instr_t     ir;      // instruction register
	instr_t     fetched; // raw word on q_a during decode
	logic       alu_valid, is_cmp, is_move, imm_zext, cond_true;
	logic       is_stor, is_jcond, is_bcond, is_halt, fetched_load;

	assign fetched = instr;

	// loads skip execute and go straight to the address phase
	assign fetched_load = (fetched.reg_form.op == op_mem) && (fetched.reg_form.ext == ext_load);

	assign is_stor  = (ir.reg_form.op == op_mem) && (ir.reg_form.ext == ext_stor);
	assign is_jcond = (ir.reg_form.op == op_mem) && (ir.reg_form.ext == ext_jcond);
	assign is_bcond = ir.imm_form.op == op_bcond;
	assign is_halt  = ir.reg_form.op == op_halt;

	// alu op and operand select
	always_comb begin
		alu_op    = alu_add;
		alu_valid = 1'b0;
		is_cmp    = 1'b0;
		is_move   = 1'b0;
		imm_sel   = 1'b0;
		imm_zext  = 1'b0;
		case (ir.reg_form.op)
			op_reg: begin
				alu_valid = 1'b1;
				case (ir.reg_form.ext)
					ext_add:  alu_op = alu_add;
					ext_addc: alu_op = alu_addc;
					ext_sub:  alu_op = alu_sub;
					ext_and:  alu_op = alu_and;
					ext_or:   alu_op = alu_or;
					ext_xor:  alu_op = alu_xor;
					ext_cmp: begin
						alu_op = alu_sub; // flags only
						is_cmp = 1'b1;
					end
					ext_mov: begin
						alu_op  = alu_pass_b;
						is_move = 1'b1;
					end
					default: alu_valid = 1'b0; // unknown ext is a nop
				endcase
			end
			op_addi: begin
				alu_valid = 1'b1;
				imm_sel   = 1'b1;
			end
			op_movi: begin
				alu_op    = alu_pass_b;
				alu_valid = 1'b1;
				is_move   = 1'b1;
				imm_sel   = 1'b1;
				imm_zext  = 1'b1;
			end
			op_cmpi: begin
				alu_op    = alu_sub;
				alu_valid = 1'b1;
				is_cmp    = 1'b1;
				imm_sel   = 1'b1;
			end
			default: ; // mem, bcond, halt and unknown ops leave the alu idle
		endcase
	end

	// movi zero-extends, addi and cmpi sign-extend
	assign imm = imm_zext ? {{(data_bits - 8){1'b0}}, ir.imm_form.imm8}
	                      : {{(data_bits - 8){ir.imm_form.imm8[7]}}, ir.imm_form.imm8};

	// condition sits in rdest for both bcond and jcond
	always_comb begin
		case (ir.imm_form.rdest)
			cond_eq: cond_true = flags_q[flag_z];
			cond_ne: cond_true = !flags_q[flag_z];
			cond_lt: cond_true = flags_q[flag_n];
			cond_ge: cond_true = !flags_q[flag_n];
			cond_lo: cond_true = flags_q[flag_l];
			cond_hs: cond_true = !flags_q[flag_l];
			cond_uc: cond_true = 1'b1;
			default: cond_true = 1'b0; // never
		endcase
	end

	always_comb begin
		case (state)
			s_fetch:    state_next = s_decode;
			s_decode:   state_next = fetched_load ? s_mem_wait : s_execute;
			s_execute:  state_next = is_halt ? s_halted : s_fetch;
			s_mem_wait: state_next = s_mem_wb;
			s_mem_wb:   state_next = s_fetch;
			s_halted:   state_next = s_halted; // only reset leaves
			default:    state_next = s_fetch;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state   <= s_fetch;
			ir      <= '0;
			flags_q <= '0;
		end else begin
			state <= state_next;
			if (state == s_decode)
				ir <= fetched; // q_a holds mem[pc] here
			if (state == s_execute && alu_valid && !is_move)
				flags_q <= flags_next; // moves keep the flags
		end
	end

	// register addresses straight from the ir
	assign waddr   = ir.reg_form.rdest;
	assign raddr_a = ir.reg_form.rdest;
	assign raddr_b = ir.reg_form.rsrc;
	assign disp    = ir.imm_form.imm8;

	// strobes
	assign mem_we = (state == s_execute) && is_stor;
	assign ls_sel = mem_we || (state == s_mem_wait); // rsrc addresses memory
	assign wb_sel = state == s_mem_wb;                // load data to rdest
	assign reg_we = ((state == s_execute) && alu_valid && !is_cmp) || (state == s_mem_wb);
	assign pc_en  = ((state == s_execute) && !is_halt) || (state == s_mem_wb);
	assign branch = (state == s_execute) && is_bcond && cond_true;
	assign jump   = (state == s_execute) && is_jcond && cond_true;
	assign halted = state == s_halted;

endmodule

`default_nettype wire

/* logic/program_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module program_counter import datapath_pkg::*; (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  en,     // one pulse per instruction
	input  wire                  branch, // condition already checked
	input  wire                  jump,
	input  wire [7:0]            disp,
	input  wire [data_bits-1:0]  target, // register rsrc
	output logic [data_bits-1:0] pc
);

	logic [data_bits-1:0] disp_ext;

	// displacement counts from the branch itself
	assign disp_ext = {{(data_bits - 8){disp[7]}}, disp};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
		end else if (en) begin
			if (jump)
				pc <= target; // absolute
			else if (branch)
				pc <= pc + disp_ext; // relative
			else
				pc <= pc + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/unified_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module unified_ram import datapath_pkg::*; #(
	parameter int addr_bits = 10
) (
	input  wire                  clk,
	input  wire [data_bits-1:0]  data_a,
	input  wire [data_bits-1:0]  data_b,
	input  wire [addr_bits-1:0]  addr_a,
	input  wire [addr_bits-1:0]  addr_b,
	input  wire                  we_a,
	input  wire                  we_b,
	output logic [data_bits-1:0] q_a,
	output logic [data_bits-1:0] q_b
);

	// program and data share one array
	logic [data_bits-1:0] mem [0:(1 << addr_bits) - 1];

	// both ports in one process
	// a same-cycle write to one word from both ports is undefined
	always_ff @(posedge clk) begin
		if (we_a)
			mem[addr_a] <= data_a; // cpu side
		if (we_b)
			mem[addr_b] <= data_b; // debug side
		q_a <= mem[addr_a]; // old data on read-during-write
		q_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

/* logic/datapath_pkg.sv */
`default_nettype none

package datapath_pkg;

	localparam int data_bits     = 16;
	localparam int reg_count     = 16;
	localparam int reg_addr_bits = 4;

	// flag word layout
	localparam int flag_bits = 5;
	localparam int flag_c    = 0; // carry out of 17-bit sum
	localparam int flag_l    = 1; // a below b, unsigned
	localparam int flag_f    = 2; // signed overflow
	localparam int flag_z    = 3; // result zero
	localparam int flag_n    = 4; // a below b, signed

	// alu operations
	localparam int alu_op_bits = 4;
	localparam logic [alu_op_bits-1:0] alu_add    = 4'd0;
	localparam logic [alu_op_bits-1:0] alu_addc   = 4'd1;
	localparam logic [alu_op_bits-1:0] alu_sub    = 4'd2; // also cmp, cmpi
	localparam logic [alu_op_bits-1:0] alu_and    = 4'd3;
	localparam logic [alu_op_bits-1:0] alu_or     = 4'd4;
	localparam logic [alu_op_bits-1:0] alu_xor    = 4'd5;
	localparam logic [alu_op_bits-1:0] alu_pass_b = 4'd6; // mov, movi

endpackage

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// two views of the same fetched word
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] rdest; // also condition code for Jcond
			logic [3:0] ext;
			logic [3:0] rsrc;
		} reg_form;
		struct packed {
			logic [3:0] op;
			logic [3:0] rdest; // condition code for Bcond
			logic [7:0] imm8;
		} imm_form;
	} instr_t;

	// major opcodes
	localparam logic [3:0] op_reg   = 4'h0; // register class, picked by ext
	localparam logic [3:0] op_mem   = 4'h4; // load, store, jcond
	localparam logic [3:0] op_addi  = 4'h5;
	localparam logic [3:0] op_cmpi  = 4'hB;
	localparam logic [3:0] op_bcond = 4'hC;
	localparam logic [3:0] op_movi  = 4'hD;
	localparam logic [3:0] op_halt  = 4'hF;

	// extension field values
	localparam logic [3:0] ext_load  = 4'h0;
	localparam logic [3:0] ext_and   = 4'h1;
	localparam logic [3:0] ext_or    = 4'h2;
	localparam logic [3:0] ext_xor   = 4'h3;
	localparam logic [3:0] ext_stor  = 4'h4;
	localparam logic [3:0] ext_add   = 4'h5;
	localparam logic [3:0] ext_addc  = 4'h7;
	localparam logic [3:0] ext_sub   = 4'h9;
	localparam logic [3:0] ext_cmp   = 4'hB;
	localparam logic [3:0] ext_jcond = 4'hC;
	localparam logic [3:0] ext_mov   = 4'hD;

	// condition codes, anything else never holds
	localparam logic [3:0] cond_eq = 4'h0; // z set
	localparam logic [3:0] cond_ne = 4'h1; // z clear
	localparam logic [3:0] cond_lo = 4'hA; // l set
	localparam logic [3:0] cond_hs = 4'hB; // l clear
	localparam logic [3:0] cond_lt = 4'hC; // n set
	localparam logic [3:0] cond_ge = 4'hD; // n clear
	localparam logic [3:0] cond_uc = 4'hE; // always

endpackage

`default_nettype wire
